/* verilog/swu_pkg.sv */
package swu_pkg;

   ////////////////////////////////////////////////////////////
   // word format
   ////////////////////////////////////////////////////////////

   localparam int SIMD     = 2;
   localparam int PREC     = 8;
   localparam int WORD_W   = SIMD * PREC;
   localparam int CHANNELS = 2;

   ////////////////////////////////////////////////////////////
   // image and kernel geometry
   ////////////////////////////////////////////////////////////

   localparam int IFM_W  = 7;
   localparam int IFM_H  = 7;
   localparam int KERNEL = 3;
   localparam int STRIDE = 2;
   localparam int OFM_W  = (IFM_W - KERNEL) / STRIDE + 1;
   localparam int OFM_H  = (IFM_H - KERNEL) / STRIDE + 1;

   // derived sizes, all counted in words
   localparam int ROW_WORDS   = IFM_W * CHANNELS;
   localparam int FRAME_WORDS = ROW_WORDS * IFM_H;
   localparam int BUF_ROWS    = KERNEL + STRIDE - 1;
   localparam int BUF_WORDS   = BUF_ROWS * ROW_WORDS;
   localparam int WIN_WORDS   = KERNEL * KERNEL * CHANNELS;

   localparam int ADDR_W = $clog2(BUF_WORDS);
   // one extra code so a full frame count still fits
   localparam int FIDX_W = $clog2(FRAME_WORDS + 1);

   // counter widths of the window position
   localparam int OROW_W = (OFM_H > 1) ? $clog2(OFM_H) : 1;
   localparam int OCOL_W = (OFM_W > 1) ? $clog2(OFM_W) : 1;
   localparam int K_W    = (KERNEL > 1) ? $clog2(KERNEL) : 1;
   localparam int CH_W   = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

   typedef logic [WORD_W-1:0] word_t;

   typedef struct packed {
      logic [OROW_W-1:0] ofm_row;
      logic [OCOL_W-1:0] ofm_col;
      logic [K_W-1:0]    kh;
      logic [K_W-1:0]    kw;
      logic [CH_W-1:0]   ch;
   } win_pos_s;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [FIDX_W-1:0] fidx;
      logic              last;
   } rd_req_s;

endpackage

/* verilog/line_buffer_ram.sv */
`timescale 1ns/1ps

module line_buffer_ram import swu_pkg::*; (
   input  logic              clk,
   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  word_t             wr_data_i,
   input  logic              rd_en_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output word_t             rd_data_o
);

   // BUF_ROWS image rows, used as a ring
   word_t mem [BUF_WORDS];

   ////////////////////////////////////////////////////////////
   // write port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // read port
   ////////////////////////////////////////////////////////////

   // output holds its word until the next read
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

/* verilog/window_addr_gen.sv */
`timescale 1ns/1ps

module window_addr_gen import swu_pkg::*; (
   input  logic     clk,
   input  logic     resetn,
   input  logic     read_fire_i,
   output win_pos_s pos_o,
   output rd_req_s  req_o
);

   win_pos_s pos;

   logic ch_end;
   logic kw_end;
   logic kh_end;
   logic col_end;
   logic row_end;

   logic [FIDX_W-1:0] row_idx;
   logic [FIDX_W-1:0] col_idx;
   logic [FIDX_W-1:0] fidx;

   ////////////////////////////////////////////////////////////
   // counter end flags
   ////////////////////////////////////////////////////////////

   assign ch_end  = pos.ch == CH_W'(CHANNELS - 1);
   assign kw_end  = pos.kw == K_W'(KERNEL - 1);
   assign kh_end  = pos.kh == K_W'(KERNEL - 1);
   assign col_end = pos.ofm_col == OCOL_W'(OFM_W - 1);
   assign row_end = pos.ofm_row == OROW_W'(OFM_H - 1);

   ////////////////////////////////////////////////////////////
   // frame index and circular address
   ////////////////////////////////////////////////////////////

   // input row of this word, scaled to words
   assign row_idx = FIDX_W'((pos.ofm_row * STRIDE + pos.kh) * ROW_WORDS);
   // input column of this word, scaled to words
   assign col_idx = FIDX_W'((pos.ofm_col * STRIDE + pos.kw) * CHANNELS);

   assign fidx = row_idx + col_idx + FIDX_W'(pos.ch);

   assign req_o.fidx = fidx;
   assign req_o.addr = ADDR_W'(fidx % BUF_WORDS);
   assign req_o.last = row_end & col_end & kh_end & kw_end & ch_end;

   assign pos_o = pos;

   ////////////////////////////////////////////////////////////
   // position counters
   ////////////////////////////////////////////////////////////

   // order from inner to outer: ch, kw, kh, ofm_col, ofm_row
   always_ff @(posedge clk) begin
      if (!resetn) begin
         pos <= '0;
      end else if (read_fire_i) begin
         if (req_o.last) begin
            // next frame starts at the first window
            pos <= '0;
         end else begin
            pos.ch <= ch_end ? '0 : pos.ch + 1'b1;
            if (ch_end) begin
               pos.kw <= kw_end ? '0 : pos.kw + 1'b1;
               if (kw_end) begin
                  pos.kh <= kh_end ? '0 : pos.kh + 1'b1;
                  if (kh_end) begin
                     pos.ofm_col <= col_end ? '0 : pos.ofm_col + 1'b1;
                     // the last row only ends together with last
                     if (col_end) begin
                        pos.ofm_row <= pos.ofm_row + 1'b1;
                     end
                  end
               end
            end
         end
      end
   end

endmodule

/* verilog/swu_ctrl.sv */
`timescale 1ns/1ps

module swu_ctrl import swu_pkg::*; (
   input  logic              clk,
   input  logic              resetn,
   input  logic              in_valid_i,
   input  win_pos_s          pos_i,
   input  rd_req_s           req_i,
   input  logic              room_i,
   output logic              in_ready_o,
   output logic              wr_en_o,
   output logic [ADDR_W-1:0] wr_addr_o,
   output logic              read_fire_o
);

   // words accepted in the current frame
   logic [FIDX_W-1:0] wr_count;
   // wr_count modulo BUF_WORDS, kept as a wrapping pointer
   logic [ADDR_W-1:0] wr_addr;
   // high for one cycle after the last read of a frame
   logic              restart;

   logic [FIDX_W-1:0] oldest;
   logic [FIDX_W-1:0] span;
   logic              credit_ok;
   logic              frame_open;
   logic              data_ready;

   ////////////////////////////////////////////////////////////
   // write side and credit
   ////////////////////////////////////////////////////////////

   // first frame index still needed by the current window row
   assign oldest = FIDX_W'(pos_i.ofm_row * STRIDE * ROW_WORDS);

   // words held that a window may still read
   assign span = wr_count - oldest;

   // a new write must not land on the oldest needed word
   assign credit_ok  = span < BUF_WORDS;
   assign frame_open = wr_count < FRAME_WORDS;

   assign in_ready_o = credit_ok & frame_open;
   assign wr_en_o    = in_valid_i & in_ready_o;
   assign wr_addr_o  = wr_addr;

   always_ff @(posedge clk) begin
      if (!resetn || restart) begin
         wr_count <= '0;
         wr_addr  <= '0;
      end else if (wr_en_o) begin
         wr_count <= wr_count + 1'b1;
         if (wr_addr == ADDR_W'(BUF_WORDS - 1)) begin
            wr_addr <= '0;
         end else begin
            wr_addr <= wr_addr + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // read gating
   ////////////////////////////////////////////////////////////

   // the requested word must already be in the buffer
   assign data_ready = req_i.fidx < wr_count;

   // no read in the restart cycle, the window is already back at zero
   // while wr_count still holds the old frame
   assign read_fire_o = data_ready & room_i & ~restart;

   ////////////////////////////////////////////////////////////
   // frame restart
   ////////////////////////////////////////////////////////////

   // window_addr_gen wraps on the same fire, see req_i.last there
   always_ff @(posedge clk) begin
      if (!resetn) begin
         restart <= 1'b0;
      end else begin
         restart <= read_fire_o & req_i.last;
      end
   end

endmodule

/* verilog/out_stage.sv */
`timescale 1ns/1ps

module out_stage import swu_pkg::*; (
   input  logic  clk,
   input  logic  resetn,
   input  logic  push_i,
   input  word_t data_i,
   input  logic  out_ready_i,
   output word_t out_data_o,
   output logic  out_valid_o,
   output logic  room_o
);

   // q is the head seen by the consumer, r the second entry
   word_t q_data;
   word_t r_data;
   logic  q_vld;
   logic  r_vld;
   // read strobe aligned with the RAM output
   logic  push_d;

   logic       pop;
   logic       q_free;
   logic       q_take_r;
   logic       q_take_in;
   logic       r_take_in;
   logic [1:0] held;

   ////////////////////////////////////////////////////////////
   // steering
   ////////////////////////////////////////////////////////////

   assign pop    = q_vld & out_ready_i;
   assign q_free = pop | ~q_vld;

   // r is older than the word coming in, so it goes first
   assign q_take_r  = q_free & r_vld;
   assign q_take_in = q_free & ~r_vld & push_d;
   assign r_take_in = push_d & ~q_take_in;

   // words held plus the one still in the RAM register
   assign held   = {1'b0, q_vld} + {1'b0, r_vld} + {1'b0, push_d};
   assign room_o = held < 2'd2;

   assign out_data_o  = q_data;
   assign out_valid_o = q_vld;

   ////////////////////////////////////////////////////////////
   // registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         push_d <= 1'b0;
         q_vld  <= 1'b0;
         r_vld  <= 1'b0;
      end else begin
         push_d <= push_i;
         if (q_free) begin
            q_vld <= r_vld | push_d;
         end
         if (r_take_in) begin
            r_vld <= 1'b1;
         end else if (q_take_r) begin
            r_vld <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (q_take_r) begin
         q_data <= r_data;
      end else if (q_take_in) begin
         q_data <= data_i;
      end
      if (r_take_in) begin
         r_data <= data_i;
      end
   end

endmodule

/* verilog/swu_top.sv */
`timescale 1ns/1ps

module swu_top import swu_pkg::*; (
   input  logic  clk,
   input  logic  resetn,
   input  word_t in_data_i,
   input  logic  in_valid_i,
   output logic  in_ready_o,
   output word_t out_data_o,
   output logic  out_valid_o,
   input  logic  out_ready_i
);

   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic              read_fire;
   logic              room;
   word_t             rd_data;
   win_pos_s          win_pos;
   rd_req_s           rd_req;

   swu_ctrl u_ctrl (
      .clk         (clk),
      .resetn      (resetn),
      .in_valid_i  (in_valid_i),
      .pos_i       (win_pos),
      .req_i       (rd_req),
      .room_i      (room),
      .in_ready_o  (in_ready_o),
      .wr_en_o     (wr_en),
      .wr_addr_o   (wr_addr),
      .read_fire_o (read_fire)
   );

   window_addr_gen u_addr_gen (
      .clk         (clk),
      .resetn      (resetn),
      .read_fire_i (read_fire),
      .pos_o       (win_pos),
      .req_o       (rd_req)
   );

   line_buffer_ram u_ram (
      .clk       (clk),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (in_data_i),
      .rd_en_i   (read_fire),
      .rd_addr_i (rd_req.addr),
      .rd_data_o (rd_data)
   );

   // the read strobe is delayed inside out_stage to line up with rd_data
   out_stage u_out (
      .clk         (clk),
      .resetn      (resetn),
      .push_i      (read_fire),
      .data_i      (rd_data),
      .out_ready_i (out_ready_i),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .room_o      (room)
   );

endmodule

/* test/swu_properties.sv */
`timescale 1ns/1ps

module swu_properties import swu_pkg::*; (
   input logic  clk,
   input logic  resetn,
   input logic  in_ready_i,
   input logic  wr_en_i,
   input logic  room_i,
   input word_t out_data_i,
   input logic  out_valid_i,
   input logic  out_ready_i
);

   // failed assertions so far
   int fail_count = 0;

   // a stalled output word keeps its value and its valid
   out_held: assert property (@(posedge clk) disable iff (!resetn)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
      else begin
         fail_count++;
         $error("output word changed or was withdrawn while stalled");
      end

   // credit is used up only by writes
   wr_credit: assert property (@(posedge clk) disable iff (!resetn)
      in_ready_i && !wr_en_i |=> in_ready_i)
      else begin
         fail_count++;
         $error("input credit was lost without a write");
      end

   // a full output stage always offers its head word
   full_head: assert property (@(posedge clk) disable iff (!resetn)
      !room_i |-> out_valid_i)
      else begin
         fail_count++;
         $error("output stage reports no room but offers no word");
      end

endmodule

bind swu_top swu_properties props_i (
   .clk         (clk),
   .resetn      (resetn),
   .in_ready_i  (in_ready_o),
   .wr_en_i     (wr_en),
   .room_i      (room),
   .out_data_i  (out_data_o),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i)
);

/* test/swu_checker.sv */
`timescale 1ns/1ps

module swu_checker import swu_pkg::*; (
   input  logic  clk,
   input  logic  resetn,
   input  word_t in_data_i,
   input  logic  in_valid_i,
   input  logic  in_ready_i,
   input  word_t out_data_i,
   input  logic  out_valid_i,
   input  logic  out_ready_i,
   output int    accepted_o,
   output int    words_o,
   output int    frames_o,
   output int    errors_o
);

   // input runs at most one frame ahead of the output
   localparam int MAX_FRAMES = 4;

   word_t frame_mem [MAX_FRAMES][FRAME_WORDS];
   string test_name = "none";

   int accepted = 0;
   int words = 0;
   int frames = 0;
   int errors = 0;
   int in_frame = 0;
   int in_idx = 0;
   int out_frame = 0;
   int w_row = 0;
   int w_col = 0;
   int w_kh = 0;
   int w_kw = 0;
   int w_ch = 0;

   assign accepted_o = accepted;
   assign words_o    = words;
   assign frames_o   = frames;
   assign errors_o   = errors;

   task automatic start_test(input string name);
      test_name = name;
   endtask

   // input word that a window word must carry
   function automatic word_t expected_word(input int frame, input int ofm_row,
                                           input int ofm_col, input int kh,
                                           input int kw, input int ch);
      int idx;
      idx = (ofm_row * STRIDE + kh) * ROW_WORDS + (ofm_col * STRIDE + kw) * CHANNELS + ch;
      return frame_mem[frame % MAX_FRAMES][idx];
   endfunction

   ////////////////////////////////////////////////////////////
   // input recorder
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!resetn) begin
         in_frame <= 0;
         in_idx   <= 0;
      end else if (in_valid_i && in_ready_i) begin
         frame_mem[in_frame % MAX_FRAMES][in_idx] <= in_data_i;
         accepted <= accepted + 1;
         if (in_idx == FRAME_WORDS - 1) begin
            in_idx   <= 0;
            in_frame <= in_frame + 1;
         end else begin
            in_idx <= in_idx + 1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // output compare
   ////////////////////////////////////////////////////////////

   // window counters from inner to outer: ch, kw, kh, col, row
   always @(posedge clk) begin
      word_t exp_w;
      if (!resetn) begin
         out_frame <= 0;
         w_row     <= 0;
         w_col     <= 0;
         w_kh      <= 0;
         w_kw      <= 0;
         w_ch      <= 0;
      end else if (out_valid_i && out_ready_i) begin
         exp_w = expected_word(out_frame, w_row, w_col, w_kh, w_kw, w_ch);
         words <= words + 1;
         if (out_data_i !== exp_w) begin
            errors <= errors + 1;
            $display("Error test %s: window (%0d,%0d) k (%0d,%0d) ch %0d expected %h actual %h",
                     test_name, w_row, w_col, w_kh, w_kw, w_ch, exp_w, out_data_i);
         end
         w_ch <= (w_ch == CHANNELS - 1) ? 0 : w_ch + 1;
         if (w_ch == CHANNELS - 1) begin
            w_kw <= (w_kw == KERNEL - 1) ? 0 : w_kw + 1;
            if (w_kw == KERNEL - 1) begin
               w_kh <= (w_kh == KERNEL - 1) ? 0 : w_kh + 1;
               if (w_kh == KERNEL - 1) begin
                  w_col <= (w_col == OFM_W - 1) ? 0 : w_col + 1;
                  if (w_col == OFM_W - 1 && w_row == OFM_H - 1) begin
                     w_row     <= 0;
                     out_frame <= out_frame + 1;
                     frames    <= frames + 1;
                  end else if (w_col == OFM_W - 1) begin
                     w_row <= w_row + 1;
                  end
               end
            end
         end
      end
   end

endmodule

/* test/swu_tb.sv */
`timescale 1ns/1ps

module swu_tb import swu_pkg::*; ();

   localparam int WIN_PER_FRAME = OFM_H * OFM_W * WIN_WORDS;

   logic  clk;
   logic  resetn;
   word_t in_data;
   logic  in_valid;
   logic  in_ready;
   word_t out_data;
   logic  out_valid;
   logic  out_ready;

   // consumer: 0 always ready, 1 never ready, 2 random
   int out_mode = 0;

   int    accepted;
   int    words;
   int    frames;
   int    errors;
   string cur_test;
   bit    test_bad;
   int    tests_run = 0;
   int    tests_failed = 0;
   int    err_base;
   int    word_base;
   int    frame_base;
   int    acc_base;

   swu_top dut_i (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_data_o  (out_data),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   swu_checker chk_i (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data),
      .in_valid_i  (in_valid),
      .in_ready_i  (in_ready),
      .out_data_i  (out_data),
      .out_valid_i (out_valid),
      .out_ready_i (out_ready),
      .accepted_o  (accepted),
      .words_o     (words),
      .frames_o    (frames),
      .errors_o    (errors)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      out_ready = 1'b0;
      forever begin
         @(posedge clk);
         case (out_mode)
            0: out_ready <= 1'b1;
            1: out_ready <= 1'b0;
            default: out_ready <= 1'($urandom_range(1));
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   task automatic apply_reset();
      @(posedge clk);
      resetn   <= 1'b0;
      in_valid <= 1'b0;
      repeat (2) @(posedge clk);
      resetn <= 1'b1;
   endtask

   task automatic begin_test(input string name, input int mode);
      @(negedge clk);
      cur_test = name;
      chk_i.start_test(name);
      out_mode = mode;
      test_bad = 1'b0;
      apply_reset();
      @(negedge clk);
      err_base   = errors;
      word_base  = words;
      frame_base = frames;
      acc_base   = accepted;
   endtask

   task automatic report_fail(input string what);
      $display("test %s: %s", cur_test, what);
      test_bad = 1'b1;
   endtask

   task automatic value_error(input string what, input int exp, input int act);
      $display("Error test %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      test_bad = 1'b1;
   endtask

   // a word stays offered until taken; stalled means no handshake for idle_limit cycles
   task automatic send_words(input int count, input int gap_pct, input int idle_limit,
                             output int sent, output bit stalled);
      int idle;
      bit fired;
      sent    = 0;
      idle    = 0;
      stalled = 1'b0;
      while (sent < count && !stalled) begin
         @(posedge clk);
         fired = in_valid && in_ready;
         if (fired) begin
            sent++;
            idle = 0;
         end else begin
            idle++;
         end
         if (sent == count) begin
            in_valid <= 1'b0;
         end else if (idle > idle_limit) begin
            stalled = 1'b1;
         end else if (fired || !in_valid) begin
            if (int'($urandom_range(99)) < gap_pct) begin
               in_valid <= 1'b0;
            end else begin
               in_valid <= 1'b1;
               in_data  <= word_t'($urandom);
            end
         end
      end
   endtask

   task automatic wait_frames(input int count);
      int cycles;
      cycles = 0;
      while (frames - frame_base < count && cycles < 5000) begin
         @(negedge clk);
         cycles++;
      end
      if (frames - frame_base < count) begin
         report_fail("timed out waiting for the output frames");
      end
   endtask

   task automatic end_test(input int exp_words);
      @(negedge clk);
      if (words - word_base != exp_words) begin
         value_error("output words", exp_words, words - word_base);
      end
      tests_run++;
      if (test_bad || errors != err_base) begin
         tests_failed++;
         $display("test %s: fail, %0d wrong words", cur_test, errors - err_base);
      end else begin
         $display("test %s: ok", cur_test);
      end
   endtask

   task automatic run_frames(input string name, input int mode, input int gap_pct,
                             input int n);
      int sent;
      bit stalled;
      begin_test(name, mode);
      send_words(n * FRAME_WORDS, gap_pct, 1000, sent, stalled);
      if (stalled) begin
         report_fail("input stalled with no handshake");
      end else begin
         wait_frames(n);
      end
      end_test(n * WIN_PER_FRAME);
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int sent;
      bit stalled;
      void'($urandom(19443));
      resetn   = 1'b0;
      in_valid = 1'b0;
      in_data  = '0;

      begin_test("reset_state", 0);
      if (out_valid !== 1'b0) value_error("out_valid_o", 0, int'(out_valid));
      if (in_ready !== 1'b1) value_error("in_ready_o", 1, int'(in_ready));
      end_test(0);

      run_frames("single_frame", 0, 0, 1);
      run_frames("three_frames", 0, 0, 3);

      // consumer blocked from reset, then released
      begin_test("backpressure", 1);
      send_words(FRAME_WORDS, 0, 100, sent, stalled);
      @(negedge clk);
      if (!stalled) report_fail("input kept flowing with the output blocked");
      if (accepted - acc_base > BUF_WORDS) begin
         value_error("accepted words", BUF_WORDS, accepted - acc_base);
      end
      out_mode = 0;
      send_words(FRAME_WORDS - sent, 0, 1000, sent, stalled);
      if (stalled) report_fail("input did not resume after release");
      else wait_frames(1);
      end_test(WIN_PER_FRAME);

      run_frames("random_flow", 2, 30, 2);

      // reset partway into a frame, then a fresh frame
      begin_test("mid_frame_reset", 2);
      send_words(40, 20, 1000, sent, stalled);
      if (stalled) report_fail("input stalled before the second reset");
      repeat (10) @(posedge clk);
      apply_reset();
      @(negedge clk);
      word_base  = words;
      frame_base = frames;
      send_words(FRAME_WORDS, 20, 1000, sent, stalled);
      if (stalled) report_fail("input stalled after the second reset");
      else wait_frames(1);
      end_test(WIN_PER_FRAME);

      @(negedge clk);
      $display("tests %0d, failed %0d, wrong words %0d, assertion failures %0d",
               tests_run, tests_failed, errors, dut_i.props_i.fail_count);
      if (tests_failed == 0 && errors == 0 && dut_i.props_i.fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
verilog/swu_pkg.sv
verilog/line_buffer_ram.sv
verilog/window_addr_gen.sv
verilog/swu_ctrl.sv
verilog/out_stage.sv
verilog/swu_top.sv
test/swu_properties.sv
test/swu_checker.sv
test/swu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := swu_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
RUN_FLAGS  := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
